/* csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// data path width
`define SYS_XLEN 32

// 1 registers the raw instruction fields and decodes after them,
// 0 decodes straight from the bus and registers the results
`define SYS_PRE_REGISTER 1

// mcause exception codes
`define SYS_CAUSE_ECALL  11  // environment call from m-mode
`define SYS_CAUSE_EBREAK 3   // breakpoint

// only bits 3:0 of the cause code are held
`define SYS_CAUSE_BITS 4

`endif

/* sys_pkg.sv */
`include "csr_cfg.svh"

package sys_pkg;

   typedef logic [`SYS_XLEN-1:0] word_t;  // csr values, operands, pc
   typedef logic [1:0]           csr_addr_t;  // index into the plain csr store
   typedef logic [4:0]           zimm_t;  // immediate of the csrr*i forms

   // straight from funct3[1:0]
   typedef enum logic [1:0] {
      CSR_NONE  = 2'b00,
      CSR_WRITE = 2'b01,
      CSR_SET   = 2'b10,
      CSR_CLEAR = 2'b11
   } csr_op_t;

   // one decoded system instruction
   typedef struct packed {
      logic      valid;
      logic      e_op;  // ecall or ebreak
      logic      ebreak;
      logic      mret;
      logic      rd_csr_en;  // csr instruction, rd gets the old value
      logic      csr_en;  // mscratch, mtvec, mepc, mtval
      csr_addr_t csr_addr;
      logic      mstatus_en;
      logic      mie_en;
      logic      mcause_en;
      csr_op_t   op;
      logic      imm_en;  // operand is zimm
      zimm_t     zimm;
      word_t     rs1;
      word_t     pc;
   } sys_dec_t;

endpackage

/* sys_decode.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module sys_decode (
   input  logic              clk,
   input  logic              i_reset,
   input  logic              i_instr_valid,
   input  sys_pkg::word_t    i_instr,
   input  sys_pkg::word_t    i_rs1,
   input  sys_pkg::word_t    i_pc,
   output sys_pkg::sys_dec_t o_dec
);
   import sys_pkg::*;

   // raw instruction fields
   logic [4:0] opcode;
   logic [2:0] funct3;
   logic       op20;
   logic       op21;
   logic       op22;
   logic       op26;
   zimm_t      imm_field;

   // decoded controls
   logic       d_e_op;
   logic       d_ebreak;
   logic       d_mret;
   logic       d_rd_csr_en;
   logic       d_csr_en;
   csr_addr_t  d_csr_addr;
   logic       d_mstatus_en;
   logic       d_mie_en;
   logic       d_mcause_en;
   csr_op_t    d_op;
   logic       d_imm_en;
   zimm_t      d_zimm;

   logic       valid_q;
   word_t      rs1_q;
   word_t      pc_q;

   logic       sys_op;
   assign sys_op = opcode[4] & opcode[2];  // only two opcode bits looked at

   // funct3 == 0 splits mret (op21) from ecall/ebreak
   wire co_rd_csr_en  = sys_op & (|funct3);
   wire co_mret       = sys_op & ~(|funct3) & op21;
   wire co_e_op       = sys_op & ~(|funct3) & ~op21;
   wire co_ebreak     = op20;

   // mstatus 0_000, mie 0_100, mcause 1_010 are held as masked regs
   // mscratch 00, mtvec 01, mepc 10, mtval 11 go to the plain store
   wire co_csr_en     = op20 | (op26 & ~op21);
   wire co_mstatus_en = ~op26 & ~op22;
   wire co_mie_en     = ~op26 & op22 & ~op20;
   wire co_mcause_en  = op21 & ~op20;
   wire csr_addr_t co_csr_addr = {op26 & op20, ~op26 | op21};
   wire csr_op_t   co_op       = csr_op_t'(funct3[1:0]);
   wire co_imm_en     = sys_op & funct3[2];

   generate
      if (`SYS_PRE_REGISTER) begin : g_pre_reg
         always_ff @(posedge clk) begin
            if (i_instr_valid) begin
               opcode    <= i_instr[6:2];
               funct3    <= i_instr[14:12];
               imm_field <= i_instr[19:15];
               op20      <= i_instr[20];
               op21      <= i_instr[21];
               op22      <= i_instr[22];
               op26      <= i_instr[26];
            end
         end

         always_comb begin
            d_e_op       = co_e_op;
            d_ebreak     = co_ebreak;
            d_mret       = co_mret;
            d_rd_csr_en  = co_rd_csr_en;
            d_csr_en     = co_csr_en;
            d_csr_addr   = co_csr_addr;
            d_mstatus_en = co_mstatus_en;
            d_mie_en     = co_mie_en;
            d_mcause_en  = co_mcause_en;
            d_op         = co_op;
            d_imm_en     = co_imm_en;
            d_zimm       = imm_field;
         end
      end else begin : g_post_reg
         always_comb begin
            opcode    = i_instr[6:2];
            funct3    = i_instr[14:12];
            imm_field = i_instr[19:15];
            op20      = i_instr[20];
            op21      = i_instr[21];
            op22      = i_instr[22];
            op26      = i_instr[26];
         end

         always_ff @(posedge clk) begin
            if (i_instr_valid) begin
               d_e_op       <= co_e_op;
               d_ebreak     <= co_ebreak;
               d_mret       <= co_mret;
               d_rd_csr_en  <= co_rd_csr_en;
               d_csr_en     <= co_csr_en;
               d_csr_addr   <= co_csr_addr;
               d_mstatus_en <= co_mstatus_en;
               d_mie_en     <= co_mie_en;
               d_mcause_en  <= co_mcause_en;
               d_op         <= co_op;
               d_imm_en     <= co_imm_en;
               d_zimm       <= imm_field;
            end
         end
      end
   endgenerate

   always_ff @(posedge clk) begin
      if (i_reset) valid_q <= 1'b0;
      else         valid_q <= i_instr_valid;
   end

   always_ff @(posedge clk) begin
      if (i_instr_valid) begin  // operands held with the instruction
         rs1_q <= i_rs1;
         pc_q  <= i_pc;
      end
   end

   always_comb begin
      o_dec.valid      = valid_q;
      o_dec.e_op       = d_e_op;
      o_dec.ebreak     = d_ebreak;
      o_dec.mret       = d_mret;
      o_dec.rd_csr_en  = d_rd_csr_en;
      o_dec.csr_en     = d_csr_en;
      o_dec.csr_addr   = d_csr_addr;
      o_dec.mstatus_en = d_mstatus_en;
      o_dec.mie_en     = d_mie_en;
      o_dec.mcause_en  = d_mcause_en;
      o_dec.op         = d_op;
      o_dec.imm_en     = d_imm_en;
      o_dec.zimm       = d_zimm;
      o_dec.rs1        = rs1_q;
      o_dec.pc         = pc_q;
   end

endmodule

/* csr_alu.sv */
`timescale 1ns/1ps

module csr_alu (
   input  sys_pkg::csr_op_t i_op,
   input  sys_pkg::word_t   i_old,
   input  sys_pkg::word_t   i_operand,
   output sys_pkg::word_t   o_new
);
   import sys_pkg::*;

   word_t set_val;
   word_t clr_val;

   assign set_val = i_old | i_operand;
   assign clr_val = i_old & ~i_operand;  // ones in the operand clear bits

   // a zero set/clear operand still writes back the unchanged value
   always_comb begin
      case (i_op)
         CSR_WRITE: begin
            o_new = i_operand;
         end
         CSR_SET: begin
            o_new = set_val;
         end
         CSR_CLEAR: begin
            o_new = clr_val;
         end
         default: begin
            o_new = i_old;  // nothing to change
         end
      endcase
   end

endmodule

/* csr_file.sv */
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_file (
   input  logic              clk,
   input  logic              i_reset,
   input  sys_pkg::sys_dec_t i_dec,
   input  sys_pkg::word_t    i_new,
   output sys_pkg::word_t    o_old,
   output sys_pkg::word_t    o_mtvec,
   output sys_pkg::word_t    o_mepc
);
   import sys_pkg::*;

   localparam csr_addr_t ADDR_MTVEC = 2'd1;
   localparam csr_addr_t ADDR_MEPC  = 2'd2;

   word_t      plain_q [4];  // mscratch, mtvec, mepc, mtval

   // held csrs, only the implemented bits
   logic       mstatus_mie;
   logic       mstatus_mpie;
   logic [2:0] mie_bits;  // meie, mtie, msie
   logic       mcause_irq;
   logic [`SYS_CAUSE_BITS-1:0] mcause_code;

   word_t      mstatus_word;
   word_t      mie_word;
   word_t      mcause_word;
   logic       csr_wr;
   logic       trap;

   assign csr_wr = i_dec.valid & i_dec.rd_csr_en;
   assign trap   = i_dec.valid & i_dec.e_op;

   // expand the held bits to full words
   always_comb begin
      mstatus_word     = '0;
      mstatus_word[3]  = mstatus_mie;
      mstatus_word[7]  = mstatus_mpie;
      mie_word         = '0;
      mie_word[3]      = mie_bits[0];
      mie_word[7]      = mie_bits[1];
      mie_word[11]     = mie_bits[2];
      mcause_word      = '0;
      mcause_word[`SYS_XLEN-1] = mcause_irq;
      mcause_word[`SYS_CAUSE_BITS-1:0] = mcause_code;
   end

   // aliased addresses may enable several sources, they are or-ed
   always_comb begin
      o_old = '0;
      if (i_dec.csr_en)     o_old = o_old | plain_q[i_dec.csr_addr];
      if (i_dec.mstatus_en) o_old = o_old | mstatus_word;
      if (i_dec.mie_en)     o_old = o_old | mie_word;
      if (i_dec.mcause_en)  o_old = o_old | mcause_word;
   end

   assign o_mtvec = plain_q[ADDR_MTVEC];
   assign o_mepc  = plain_q[ADDR_MEPC];

   always_ff @(posedge clk) begin
      if (csr_wr && i_dec.csr_en) plain_q[i_dec.csr_addr] <= i_new;
      else if (trap)              plain_q[ADDR_MEPC] <= i_dec.pc;  // return address
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_bits     <= '0;
         mcause_irq   <= 1'b0;
         mcause_code  <= '0;
      end else if (i_dec.valid) begin
         if (i_dec.rd_csr_en) begin
            if (i_dec.mstatus_en) begin
               mstatus_mie  <= i_new[3];
               mstatus_mpie <= i_new[7];
            end
            if (i_dec.mie_en) mie_bits <= {i_new[11], i_new[7], i_new[3]};
            if (i_dec.mcause_en) begin
               mcause_irq  <= i_new[`SYS_XLEN-1];
               mcause_code <= i_new[`SYS_CAUSE_BITS-1:0];
            end
         end
         if (i_dec.e_op) begin
            mcause_irq   <= 1'b0;  // exceptions only
            mcause_code  <= i_dec.ebreak ? `SYS_CAUSE_BITS'(`SYS_CAUSE_EBREAK)
                                         : `SYS_CAUSE_BITS'(`SYS_CAUSE_ECALL);
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
         end
         if (i_dec.mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
         end
      end
   end

endmodule

/* sys_unit.sv */
`timescale 1ns/1ps

module sys_unit (
   input  logic           clk,
   input  logic           i_reset,
   input  logic           i_instr_valid,
   input  sys_pkg::word_t i_instr,
   input  sys_pkg::word_t i_rs1,
   input  sys_pkg::word_t i_pc,
   output logic           o_done,
   output logic           o_rd_we,
   output sys_pkg::word_t o_rd_data,
   output logic           o_jump,
   output sys_pkg::word_t o_jump_addr
);
   import sys_pkg::*;

   sys_dec_t dec;
   word_t    operand;
   word_t    old_val;
   word_t    new_val;
   word_t    mtvec;
   word_t    mepc;

   sys_decode u_decode (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_rs1         (i_rs1),
      .i_pc          (i_pc),
      .o_dec         (dec)
   );

   // zimm is zero extended
   assign operand = dec.imm_en ? word_t'(dec.zimm) : dec.rs1;

   csr_alu u_alu (
      .i_op      (dec.op),
      .i_old     (old_val),
      .i_operand (operand),
      .o_new     (new_val)
   );

   csr_file u_csr (
      .clk     (clk),
      .i_reset (i_reset),
      .i_dec   (dec),
      .i_new   (new_val),
      .o_old   (old_val),
      .o_mtvec (mtvec),
      .o_mepc  (mepc)
   );

   assign o_done      = dec.valid;  // one cycle after the strobe
   assign o_rd_we     = dec.valid & dec.rd_csr_en;
   assign o_rd_data   = old_val;
   assign o_jump      = dec.valid & (dec.e_op | dec.mret);
   assign o_jump_addr = dec.mret ? mepc : mtvec;  // trap goes to mtvec

endmodule

/* sys_unit_assertions.sv */
`timescale 1ns/1ps

module sys_unit_assertions (
   input logic clk,
   input logic i_reset,
   input logic i_instr_valid,
   input logic i_done,
   input logic i_rd_we,
   input logic i_jump
);

   // fixed one cycle latency, both ways
   a_done_after_strobe: assert property (@(posedge clk) disable iff (i_reset)
      i_instr_valid |=> i_done)
      else $error("o_done missing one cycle after a strobe");

   a_no_stray_done: assert property (@(posedge clk) disable iff (i_reset)
      !i_instr_valid |=> !i_done)
      else $error("o_done high without a strobe in the cycle before");

   a_outputs_with_done: assert property (@(posedge clk) disable iff (i_reset)
      (i_rd_we || i_jump) |-> i_done)
      else $error("o_rd_we or o_jump high without o_done");

   a_we_jump_exclusive: assert property (@(posedge clk) disable iff (i_reset)
      !(i_rd_we && i_jump))
      else $error("o_rd_we and o_jump high together");

   a_quiet_in_reset: assert property (@(posedge clk)
      i_reset |=> !i_done)
      else $error("o_done pulse during reset");

endmodule

bind sys_unit sys_unit_assertions u_assertions (
   .clk           (clk),
   .i_reset       (i_reset),
   .i_instr_valid (i_instr_valid),
   .i_done        (o_done),
   .i_rd_we       (o_rd_we),
   .i_jump        (o_jump)
);

/* sys_unit_tb.sv */
`timescale 1ns/1ps

module sys_unit_tb;
   import sys_pkg::*;

   localparam int    MAX_CYCLES   = 200;  // tests take about 55 cycles
   localparam word_t MASK_MSTATUS = 32'h0000_0088;  // mpie, mie
   localparam word_t MASK_MIE     = 32'h0000_0888;
   localparam word_t MASK_MCAUSE  = 32'h8000_000f;

   logic   clk;
   logic   i_reset;
   logic   i_instr_valid;
   word_t  i_instr;
   word_t  i_rs1;
   word_t  i_pc;
   logic   o_done;
   logic   o_rd_we;
   word_t  o_rd_data;
   logic   o_jump;
   word_t  o_jump_addr;

   // reference state, held already masked
   word_t  ref_mstatus;
   word_t  ref_mie;
   word_t  ref_mcause;
   word_t  ref_plain [4];  // mscratch, mtvec, mepc, mtval

   integer seed = 64;
   int     cycles = 0;
   int     errors = 0;
   int     test_errors = 0;
   int     checks = 0;
   int     tests_run = 0;
   int     done_count = 0;

   sys_unit dut0 (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .i_rs1         (i_rs1),
      .i_pc          (i_pc),
      .o_done        (o_done),
      .o_rd_we       (o_rd_we),
      .o_rd_data     (o_rd_data),
      .o_jump        (o_jump),
      .o_jump_addr   (o_jump_addr)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: no end of tests after %0d cycles", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (o_done) done_count = done_count + 1;  // pulses counted mid cycle
   end

   function automatic word_t ref_read(input logic [11:0] csr);
      case (csr)
         12'h300: return ref_mstatus;
         12'h304: return ref_mie;
         12'h342: return ref_mcause;
         12'h340: return ref_plain[0];
         12'h305: return ref_plain[1];
         12'h341: return ref_plain[2];
         default: return ref_plain[3];
      endcase
   endfunction

   task automatic ref_write(input logic [11:0] csr, input word_t val);
      case (csr)
         12'h300: ref_mstatus = val & MASK_MSTATUS;
         12'h304: ref_mie = val & MASK_MIE;
         12'h342: ref_mcause = val & MASK_MCAUSE;
         12'h340: ref_plain[0] = val;
         12'h305: ref_plain[1] = val;
         12'h341: ref_plain[2] = val;
         default: ref_plain[3] = val;
      endcase
   endtask

   task automatic check(input string name, input word_t got, input word_t exp);
      checks = checks + 1;
      if (got !== exp) begin
         $display("error: %s is %h, expected %h", name, got, exp);
         test_errors = test_errors + 1;
      end
   endtask

   // strobe for one cycle, then wait for done
   task automatic issue(input word_t instr, input word_t rs1, input word_t pc);
      i_instr       = instr;
      i_rs1         = rs1;
      i_pc          = pc;
      i_instr_valid = 1'b1;
      @(posedge clk);
      #5;
      i_instr_valid = 1'b0;
      while (o_done !== 1'b1) begin
         @(posedge clk);
         #5;
      end
   endtask

   task automatic csr_op(input logic [2:0] f3, input logic [11:0] csr, input word_t rs1,
                         input logic [4:0] zimm);
      word_t old_v;
      word_t operand;
      word_t new_v;
      old_v   = ref_read(csr);
      operand = f3[2] ? {27'd0, zimm} : rs1;
      case (f3[1:0])
         2'b01:   new_v = operand;
         2'b10:   new_v = old_v | operand;
         2'b11:   new_v = old_v & ~operand;
         default: new_v = old_v;
      endcase
      issue({csr, zimm, f3, 5'd1, 7'h73}, rs1, 32'd0);
      check("o_rd_we", o_rd_we, 1);
      check("o_jump", o_jump, 0);
      check("o_rd_data", o_rd_data, old_v);
      ref_write(csr, new_v);
   endtask

   task automatic trap_op(input logic is_ebreak, input word_t pc);
      issue(is_ebreak ? 32'h0010_0073 : 32'h0000_0073, 32'd0, pc);
      check("o_jump", o_jump, 1);
      check("o_rd_we", o_rd_we, 0);
      check("o_jump_addr", o_jump_addr, ref_plain[1]);
      ref_plain[2] = pc;
      ref_mcause   = is_ebreak ? 32'd3 : 32'd11;
      ref_mstatus  = ref_mstatus[3] ? 32'h80 : 32'h00;  // mie into mpie
   endtask

   task automatic mret_op();
      issue(32'h3020_0073, 32'd0, 32'd0);
      check("o_jump", o_jump, 1);
      check("o_rd_we", o_rd_we, 0);
      check("o_jump_addr", o_jump_addr, ref_plain[2]);
      ref_mstatus = ref_mstatus[7] ? 32'h88 : 32'h80;
   endtask

   task automatic end_test(input string name);
      tests_run = tests_run + 1;
      errors    = errors + test_errors;
      $display("test %0d %s: %s, %0d errors", tests_run, name,
               (test_errors == 0) ? "ok" : "mismatch", test_errors);
      test_errors = 0;
   endtask

   task automatic test_reset_values();
      csr_op(3'b010, 12'h300, 32'd0, 5'd0);
      csr_op(3'b010, 12'h304, 32'd0, 5'd0);
      csr_op(3'b010, 12'h342, 32'd0, 5'd0);
      end_test("reset values");
   endtask

   task automatic test_write_read();
      logic [11:0] csrs [7] = '{12'h300, 12'h304, 12'h342, 12'h340,
                                12'h305, 12'h341, 12'h343};
      foreach (csrs[k]) begin
         csr_op(3'b001, csrs[k], $random(seed), 5'd0);
         csr_op(3'b001, csrs[k], $random(seed), 5'd0);  // rd is the first write
         csr_op(3'b010, csrs[k], 32'd0, 5'd0);
      end
      end_test("write and read back");
   endtask

   task automatic test_set_clear();
      csr_op(3'b010, 12'h340, $random(seed), 5'd0);
      csr_op(3'b011, 12'h340, $random(seed), 5'd0);
      csr_op(3'b110, 12'h340, 32'd0, 5'h15);
      csr_op(3'b111, 12'h340, 32'd0, 5'h0a);
      csr_op(3'b110, 12'h304, 32'd0, 5'h08);
      csr_op(3'b010, 12'h304, 32'h0000_0880, 5'd0);
      csr_op(3'b011, 12'h304, 32'h0000_0088, 5'd0);
      csr_op(3'b010, 12'h340, 32'd0, 5'd0);
      csr_op(3'b010, 12'h304, 32'd0, 5'd0);
      end_test("set and clear");
   endtask

   task automatic test_traps();
      csr_op(3'b110, 12'h300, 32'd0, 5'h08);  // mie on before the trap
      trap_op(1'b0, $random(seed));
      csr_op(3'b010, 12'h341, 32'd0, 5'd0);
      csr_op(3'b010, 12'h342, 32'd0, 5'd0);
      csr_op(3'b010, 12'h300, 32'd0, 5'd0);
      trap_op(1'b1, $random(seed));
      csr_op(3'b010, 12'h342, 32'd0, 5'd0);
      csr_op(3'b010, 12'h341, 32'd0, 5'd0);
      end_test("ecall and ebreak");
   endtask

   task automatic test_mret_other();
      csr_op(3'b001, 12'h300, 32'h0000_0080, 5'd0);
      csr_op(3'b001, 12'h341, $random(seed), 5'd0);
      mret_op();
      csr_op(3'b010, 12'h300, 32'd0, 5'd0);
      issue(32'h0050_0093, $random(seed), 32'd0);  // addi, not a system op
      check("o_rd_we", o_rd_we, 0);
      check("o_jump", o_jump, 0);
      end_test("mret and other opcode");
   endtask

   task automatic test_back_to_back();
      int start_count;
      @(posedge clk);  // idle cycle, the last done pulse is counted by now
      #5;
      start_count = done_count;
      csr_op(3'b001, 12'h343, $random(seed), 5'd0);
      csr_op(3'b010, 12'h343, 32'd0, 5'd0);
      @(posedge clk);
      #5;
      checks = checks + 1;
      if (o_done !== 1'b0) begin
         $display("done pulse seen with no strobe before it");
         test_errors = test_errors + 1;
      end
      checks = checks + 1;
      if (done_count - start_count != 2) begin
         $display("two strobes gave %0d done pulses", done_count - start_count);
         test_errors = test_errors + 1;
      end
      end_test("back to back");
   endtask

   initial begin
      i_reset       = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      i_rs1         = '0;
      i_pc          = '0;
      ref_mstatus   = '0;
      ref_mie       = '0;
      ref_mcause    = '0;
      repeat (3) @(posedge clk);
      #5;
      i_reset = 1'b0;
      test_reset_values();
      test_write_read();
      test_set_clear();
      test_traps();
      test_mret_other();
      test_back_to_back();
      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* src.f */
+incdir+.
sys_pkg.sv
sys_decode.sv
csr_alu.sv
csr_file.sv
sys_unit.sv
sys_unit_assertions.sv
sys_unit_tb.sv

/* Bender.yml */
package:
  name: sys_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sys_pkg.sv
      - sys_decode.sv
      - csr_alu.sv
      - csr_file.sv
      - sys_unit.sv
  - target: test
    files:
      - sys_unit_assertions.sv
      - sys_unit_tb.sv
